// File: all.f
+incdir+design
design/mem_types_pkg.sv
design/line_arbiter.sv
design/direct_mapped_l2.sv
design/line_return_stage.sv
design/mem_subsystem_top.sv
testbench/pmem_model.sv
testbench/tb_mem_subsystem.sv

// File: design/direct_mapped_l2.sv
`timescale 1ns/1ns
`include "l2_cfg.svh"

module direct_mapped_l2 (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mem_types_pkg::line_req_t  l2_req,
	output mem_types_pkg::line_ret_t  l2_ret,
	output logic                      pmem_read,
	output logic                      pmem_write,
	output mem_types_pkg::addr_t      pmem_address,
	output mem_types_pkg::line_t      pmem_wdata,
	input  logic                      pmem_resp,
	input  mem_types_pkg::line_t      pmem_rdata
);

	// byte offset within a line
	localparam int OFFSET_BITS = $clog2(`L2_LINE_BITS / 8);
	localparam int INDEX_BITS  = $clog2(`L2_SETS);
	localparam int TAG_BITS    = `L2_ADDR_BITS - INDEX_BITS - OFFSET_BITS;

	mem_types_pkg::l2_state_e state;
	mem_types_pkg::l2_state_e state_next;

	// line storage and tags
	mem_types_pkg::line_t     data_arr [`L2_SETS];
	logic [TAG_BITS-1:0]      tag_arr  [`L2_SETS];
	logic [`L2_SETS-1:0]      valid_arr;
	logic [`L2_SETS-1:0]      dirty_arr;

	logic [INDEX_BITS-1:0]    req_index;
	logic [TAG_BITS-1:0]      req_tag;
	logic                     hit;
	// victim must go back to pmem before the fill
	logic                     victim_dirty;

	// address split, request held by the arbiter throughout
	always_comb begin
		req_index    = l2_req.address[OFFSET_BITS +: INDEX_BITS];
		req_tag      = l2_req.address[`L2_ADDR_BITS-1 -: TAG_BITS];
		hit          = valid_arr[req_index] && (tag_arr[req_index] == req_tag);
		victim_dirty = valid_arr[req_index] && dirty_arr[req_index];
	end

	// next state
	always_comb begin
		state_next = state;
		case (state)
			mem_types_pkg::l2_idle: begin
				if (l2_req.read || l2_req.write) begin
					state_next = mem_types_pkg::l2_lookup;
				end
			end
			mem_types_pkg::l2_lookup: begin
				if (hit) begin
					state_next = mem_types_pkg::l2_done;
				end else if (victim_dirty) begin
					state_next = mem_types_pkg::l2_writeback;
				end else begin
					state_next = mem_types_pkg::l2_fill;
				end
			end
			mem_types_pkg::l2_writeback: begin
				if (pmem_resp) begin
					state_next = mem_types_pkg::l2_fill;
				end
			end
			// after the fill, look up again and serve as a hit
			mem_types_pkg::l2_fill: begin
				if (pmem_resp) begin
					state_next = mem_types_pkg::l2_lookup;
				end
			end
			mem_types_pkg::l2_done: begin
				state_next = mem_types_pkg::l2_idle;
			end
			default: begin
				state_next = mem_types_pkg::l2_idle;
			end
		endcase
	end

	// state, valid and dirty bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= mem_types_pkg::l2_idle;
			valid_arr <= '0;
			dirty_arr <= '0;
		end else begin
			state <= state_next;
			// write hit marks the line dirty
			if (state == mem_types_pkg::l2_lookup && hit && l2_req.write) begin
				dirty_arr[req_index] <= 1'b1;
			end
			// fresh line from pmem is clean
			if (state == mem_types_pkg::l2_fill && pmem_resp) begin
				valid_arr[req_index] <= 1'b1;
				dirty_arr[req_index] <= 1'b0;
			end
		end
	end

	// line data and tags
	always_ff @(posedge clk) begin
		if (state == mem_types_pkg::l2_lookup && hit && l2_req.write) begin
			data_arr[req_index] <= l2_req.wdata;
		end
		if (state == mem_types_pkg::l2_fill && pmem_resp) begin
			data_arr[req_index] <= pmem_rdata;
			tag_arr[req_index]  <= req_tag;
		end
	end

	// pmem side, victim address during writeback
	always_comb begin
		pmem_read  = (state == mem_types_pkg::l2_fill);
		pmem_write = (state == mem_types_pkg::l2_writeback);
		pmem_wdata = data_arr[req_index];
		if (state == mem_types_pkg::l2_writeback) begin
			pmem_address = {tag_arr[req_index], req_index, {OFFSET_BITS{1'b0}}};
		end else begin
			pmem_address = {req_tag, req_index, {OFFSET_BITS{1'b0}}};
		end
	end

	// answer straight from the state register
	always_comb begin
		l2_ret.resp  = (state == mem_types_pkg::l2_done);
		l2_ret.rdata = data_arr[req_index];
	end

endmodule

// File: design/l2_cfg.svh
`ifndef L2_CFG_SVH
`define L2_CFG_SVH

// sizing of the memory side below the L1 caches

// one cache line, as moved between L1, L2 and pmem
`define L2_LINE_BITS 256

// byte address width
// requests arrive line aligned
`define L2_ADDR_BITS 32

// number of direct-mapped L2 sets
// must be a power of two, at least 2
`define L2_SETS 16

`endif

// File: design/line_arbiter.sv
`timescale 1ns/1ns

module line_arbiter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      iread,
	input  mem_types_pkg::addr_t      iaddress,
	input  mem_types_pkg::line_req_t  d_req,
	input  logic                      l2_ret_resp,
	output mem_types_pkg::line_req_t  l2_req,
	output mem_types_pkg::owner_e     owner
);

	mem_types_pkg::arb_state_e state;
	// latched copy of the granted request
	mem_types_pkg::line_req_t  req_q;
	// icache side always reads
	mem_types_pkg::line_req_t  inst_req;
	// set when the data side was served last
	logic                      last_data;
	// one cycle after the L2 answers
	// served port still holds its request then
	logic                      hold_off;
	logic                      i_want;
	logic                      d_want;
	logic                      pick_data;

	always_comb begin
		inst_req.read    = 1'b1;
		inst_req.write   = 1'b0;
		inst_req.address = iaddress;
		inst_req.wdata   = '0;
	end

	// mask the port just served until its request has dropped
	always_comb begin
		i_want = iread && !(hold_off && !last_data);
		d_want = (d_req.read || d_req.write) && !(hold_off && last_data);
		// on a tie the side not served last goes first
		pick_data = d_want && (!i_want || !last_data);
	end

	// grant FSM and round-robin bookkeeping
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= mem_types_pkg::arb_idle;
			owner     <= mem_types_pkg::own_none;
			last_data <= 1'b0;
			hold_off  <= 1'b0;
		end else begin
			hold_off <= 1'b0;
			case (state)
				mem_types_pkg::arb_idle: begin
					if (i_want || d_want) begin
						state     <= mem_types_pkg::arb_busy;
						owner     <= pick_data ? mem_types_pkg::own_data
							: mem_types_pkg::own_inst;
						last_data <= pick_data;
					end
				end
				mem_types_pkg::arb_busy: begin
					// L2 done, free the grant so the request drops in time
					if (l2_ret_resp) begin
						state    <= mem_types_pkg::arb_idle;
						owner    <= mem_types_pkg::own_none;
						hold_off <= 1'b1;
					end
				end
				default: begin
					state <= mem_types_pkg::arb_idle;
					owner <= mem_types_pkg::own_none;
				end
			endcase
		end
	end

	// payload capture at grant time
	always_ff @(posedge clk) begin
		if (state == mem_types_pkg::arb_idle && (i_want || d_want)) begin
			req_q <= pick_data ? d_req : inst_req;
		end
	end

	// request only visible while a grant is held
	always_comb begin
		l2_req.read    = (state == mem_types_pkg::arb_busy) && req_q.read;
		l2_req.write   = (state == mem_types_pkg::arb_busy) && req_q.write;
		l2_req.address = req_q.address;
		l2_req.wdata   = req_q.wdata;
	end

endmodule

// File: design/line_return_stage.sv
`timescale 1ns/1ns

module line_return_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mem_types_pkg::line_ret_t  l2_ret,
	input  mem_types_pkg::owner_e     owner,
	output logic                      iresp,
	output logic                      dresp,
	output mem_types_pkg::line_t      rdata
);

	// resp pulse goes to whoever held the grant
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			iresp <= 1'b0;
			dresp <= 1'b0;
		end else begin
			iresp <= l2_ret.resp && (owner == mem_types_pkg::own_inst);
			dresp <= l2_ret.resp && (owner == mem_types_pkg::own_data);
		end
	end

	// line held until the next answer
	always_ff @(posedge clk) begin
		if (l2_ret.resp) begin
			rdata <= l2_ret.rdata;
		end
	end

endmodule

// File: design/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      iread,
	input  mem_types_pkg::addr_t      iaddress,
	output logic                      iresp,
	output mem_types_pkg::line_t      i_rdata,
	input  mem_types_pkg::line_req_t  d_req,
	output logic                      dresp,
	output mem_types_pkg::line_t      d_rdata,
	output logic                      pmem_read,
	output logic                      pmem_write,
	output mem_types_pkg::addr_t      pmem_address,
	output mem_types_pkg::line_t      pmem_wdata,
	input  logic                      pmem_resp,
	input  mem_types_pkg::line_t      pmem_rdata
);

	// arbiter to L2
	mem_types_pkg::line_req_t l2_req;
	// L2 to arbiter and return stage
	mem_types_pkg::line_ret_t l2_ret;
	mem_types_pkg::owner_e    owner;
	mem_types_pkg::line_t     rdata;

	line_arbiter u_line_arbiter (
		.clk         (clk),
		.rst_n       (rst_n),
		.iread       (iread),
		.iaddress    (iaddress),
		.d_req       (d_req),
		.l2_ret_resp (l2_ret.resp),
		.l2_req      (l2_req),
		.owner       (owner)
	);

	direct_mapped_l2 u_direct_mapped_l2 (
		.clk          (clk),
		.rst_n        (rst_n),
		.l2_req       (l2_req),
		.l2_ret       (l2_ret),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.pmem_resp    (pmem_resp),
		.pmem_rdata   (pmem_rdata)
	);

	line_return_stage u_line_return_stage (
		.clk    (clk),
		.rst_n  (rst_n),
		.l2_ret (l2_ret),
		.owner  (owner),
		.iresp  (iresp),
		.dresp  (dresp),
		.rdata  (rdata)
	);

	// both L1 sides see the same line, resp says whose it is
	assign i_rdata = rdata;
	assign d_rdata = rdata;

endmodule

// File: design/mem_types_pkg.sv
`include "l2_cfg.svh"

package mem_types_pkg;

	// whole cache line
	typedef logic [`L2_LINE_BITS-1:0] line_t;

	// byte address, line aligned in use
	typedef logic [`L2_ADDR_BITS-1:0] addr_t;

	// one line request toward the L2
	typedef struct packed {
		logic  read;
		logic  write;
		addr_t address;
		line_t wdata;
	} line_req_t;

	// L2 answer, rdata only meaningful on a read
	typedef struct packed {
		logic  resp;
		line_t rdata;
	} line_ret_t;

	// who holds the L2 grant
	typedef enum logic [1:0] {
		own_none,
		own_inst,
		own_data
	} owner_e;

	typedef enum logic {
		arb_idle,
		arb_busy
	} arb_state_e;

	typedef enum logic [2:0] {
		l2_idle,
		l2_lookup,
		l2_writeback,
		l2_fill,
		l2_done
	} l2_state_e;

endpackage

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_mem_subsystem \
	-o tb_mem_subsystem
./obj_dir/tb_mem_subsystem > sim.log
cat sim.log

if grep -q "sim failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

// File: testbench/pmem_model.sv
`timescale 1ns/1ns

module pmem_model (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pmem_read,
	input  logic                  pmem_write,
	input  mem_types_pkg::addr_t  pmem_address,
	input  mem_types_pkg::line_t  pmem_wdata,
	output logic                  pmem_resp,
	output mem_types_pkg::line_t  pmem_rdata
);

	// cycles from a raised access to its resp
	localparam int DELAY = 3;

	// only lines that were written are stored
	mem_types_pkg::line_t store [mem_types_pkg::addr_t];
	int unsigned          wait_cnt;

	// untouched memory, each 32-bit word holds its own byte address
	function automatic mem_types_pkg::line_t initial_line(input mem_types_pkg::addr_t a);
		mem_types_pkg::line_t l;
		for (int w = 0; w < $bits(mem_types_pkg::line_t) / 32; w++) begin
			l[w*32 +: 32] = a + 32'(4 * w);
		end
		return l;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pmem_resp <= 1'b0;
			wait_cnt  <= 0;
		end else begin
			pmem_resp <= 1'b0;
			// no counting while resp is out
			if ((pmem_read || pmem_write) && !pmem_resp) begin
				if (wait_cnt == DELAY - 1) begin
					pmem_resp <= 1'b1;
					wait_cnt  <= 0;
					if (pmem_write) begin
						store[pmem_address] = pmem_wdata;
					end else if (store.exists(pmem_address)) begin
						pmem_rdata <= store[pmem_address];
					end else begin
						pmem_rdata <= initial_line(pmem_address);
					end
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
		end
	end

endmodule

// File: testbench/tb_mem_subsystem.sv
`timescale 1ns/1ns
`include "l2_cfg.svh"

module tb_mem_subsystem;

	// lowest address bit above the set index
	localparam int TAG_LSB      = $clog2(`L2_LINE_BITS / 8) + $clog2(`L2_SETS);
	localparam int RESP_TIMEOUT = 200;

	logic                     clk = 1'b0;
	logic                     rst_n;
	logic                     iread;
	mem_types_pkg::addr_t     iaddress;
	logic                     iresp;
	mem_types_pkg::line_t     i_rdata;
	mem_types_pkg::line_req_t d_req;
	logic                     dresp;
	mem_types_pkg::line_t     d_rdata;
	logic                     pmem_read;
	logic                     pmem_write;
	mem_types_pkg::addr_t     pmem_address;
	mem_types_pkg::line_t     pmem_wdata;
	logic                     pmem_resp;
	mem_types_pkg::line_t     pmem_rdata;

	// expected lines per port, set with each request
	mem_types_pkg::line_t     d_expect;
	mem_types_pkg::line_t     i_expect;
	logic                     d_is_read;
	// writeback watch for the eviction case
	logic                     wb_watch;
	mem_types_pkg::addr_t     wb_addr;
	mem_types_pkg::line_t     wb_data;
	logic                     wb_seen = 1'b0;
	// low in reset and in the cycle after
	logic                     rst_q;
	// every line written so far
	mem_types_pkg::line_t     ref_img [mem_types_pkg::addr_t];
	int                       err_count = 0;
	int                       timeout_count = 0;
	bit                       timed_out = 1'b0;

	mem_subsystem_top u_mem_subsystem_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.iread        (iread),
		.iaddress     (iaddress),
		.iresp        (iresp),
		.i_rdata      (i_rdata),
		.d_req        (d_req),
		.dresp        (dresp),
		.d_rdata      (d_rdata),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.pmem_resp    (pmem_resp),
		.pmem_rdata   (pmem_rdata)
	);

	pmem_model u_pmem_model (
		.clk          (clk),
		.rst_n        (rst_n),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.pmem_resp    (pmem_resp),
		.pmem_rdata   (pmem_rdata)
	);

	always #50 clk = ~clk;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rst_q <= 1'b0;
		end else begin
			rst_q <= 1'b1;
		end
	end

	always @(posedge clk) begin
		if (wb_watch && pmem_write && pmem_resp) begin
			wb_seen <= 1'b1;
		end
	end

	reset_quiet: assert property (@(posedge clk)
		(!rst_n || !rst_q) |-> !iresp && !dresp && !pmem_read && !pmem_write)
		else begin
			err_count++;
			$display("[FAIL] %0t: resp or pmem access active around reset", $time);
		end

	data_line_ok: assert property (@(posedge clk) disable iff (!rst_n)
		(dresp && d_is_read) |-> d_rdata == d_expect)
		else begin
			err_count++;
			$display("[FAIL] %0t: data read got %h, expected %h", $time, d_rdata, d_expect);
		end

	inst_line_ok: assert property (@(posedge clk) disable iff (!rst_n)
		iresp |-> i_rdata == i_expect)
		else begin
			err_count++;
			$display("[FAIL] %0t: inst read got %h, expected %h", $time, i_rdata, i_expect);
		end

	dresp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
		dresp |-> (d_req.read || d_req.write))
		else begin
			err_count++;
			$display("[FAIL] %0t: dresp without a data request", $time);
		end

	iresp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
		iresp |-> iread)
		else begin
			err_count++;
			$display("[FAIL] %0t: iresp without an inst request", $time);
		end

	// victim goes out with the line written before
	writeback_ok: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_watch && pmem_write) |-> pmem_address == wb_addr && pmem_wdata == wb_data)
		else begin
			err_count++;
			$display("[FAIL] %0t: writeback to %h, expected %h", $time, pmem_address, wb_addr);
		end

	// word at byte address A holds A in untouched memory
	function automatic mem_types_pkg::line_t cold_line(input mem_types_pkg::addr_t a);
		mem_types_pkg::line_t l;
		for (int w = 0; w < `L2_LINE_BITS / 32; w++) begin
			l[w*32 +: 32] = a + 32'(4 * w);
		end
		return l;
	endfunction

	function automatic mem_types_pkg::line_t expected_line(input mem_types_pkg::addr_t a);
		if (ref_img.exists(a)) begin
			return ref_img[a];
		end
		return cold_line(a);
	endfunction

	function automatic mem_types_pkg::line_t random_line();
		mem_types_pkg::line_t l;
		for (int w = 0; w < `L2_LINE_BITS / 32; w++) begin
			l[w*32 +: 32] = $urandom;
		end
		return l;
	endfunction

	function automatic mem_types_pkg::addr_t random_line_addr();
		mem_types_pkg::addr_t a;
		a = $urandom;
		a[$clog2(`L2_LINE_BITS / 8)-1:0] = '0;
		return a;
	endfunction

	// one data-side transaction held until dresp
	task automatic data_access(input logic is_write, input mem_types_pkg::addr_t addr,
			input mem_types_pkg::line_t wdata);
		int  waited;
		logic got;
		if (timed_out) begin
			return;
		end
		@(posedge clk);
		d_expect      <= is_write ? wdata : expected_line(addr);
		d_is_read     <= !is_write;
		d_req.read    <= !is_write;
		d_req.write   <= is_write;
		d_req.address <= addr;
		d_req.wdata   <= wdata;
		waited = 0;
		got    = 1'b0;
		while (!got && waited < RESP_TIMEOUT) begin
			@(posedge clk);
			waited++;
			got = dresp;
		end
		// drop in the cycle after resp
		d_req <= '0;
		if (!got) begin
			timeout_count++;
			timed_out = 1'b1;
			$display("timeout: data port never got a response for address %h", addr);
		end else if (is_write) begin
			ref_img[addr] = wdata;
		end
	endtask

	task automatic inst_read(input mem_types_pkg::addr_t addr);
		int  waited;
		logic got;
		if (timed_out) begin
			return;
		end
		@(posedge clk);
		i_expect <= expected_line(addr);
		iread    <= 1'b1;
		iaddress <= addr;
		waited = 0;
		got    = 1'b0;
		while (!got && waited < RESP_TIMEOUT) begin
			@(posedge clk);
			waited++;
			got = iresp;
		end
		iread <= 1'b0;
		if (!got) begin
			timeout_count++;
			timed_out = 1'b1;
			$display("timeout: inst port never got a response for address %h", addr);
		end
	endtask

	initial begin
		mem_types_pkg::addr_t a;
		mem_types_pkg::addr_t b;
		mem_types_pkg::line_t wd;
		rst_n     = 1'b0;
		iread     = 1'b0;
		iaddress  = '0;
		d_req     = '0;
		d_is_read = 1'b0;
		wb_watch  = 1'b0;
		void'($urandom(7));
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// cold reads on both ports
		data_access(1'b0, random_line_addr(), '0);
		inst_read(random_line_addr());

		// write and read back
		a  = random_line_addr();
		wd = random_line();
		data_access(1'b1, a, wd);
		data_access(1'b0, a, '0);

		// same index with another tag forces the dirty line out
		a  = random_line_addr();
		b  = a ^ (mem_types_pkg::addr_t'(1) << TAG_LSB);
		wd = random_line();
		data_access(1'b1, a, wd);
		@(posedge clk);
		wb_addr  <= a;
		wb_data  <= wd;
		wb_watch <= 1'b1;
		data_access(1'b0, b, '0);
		@(posedge clk);
		wb_watch <= 1'b0;
		if (!timed_out) begin
			dirty_written_back: assert (wb_seen) else begin
				err_count++;
				$display("the dirty line was never written back to pmem");
			end
		end
		data_access(1'b0, a, '0);

		// both ports at once with data served last so inst wins
		a = random_line_addr();
		b = random_line_addr();
		fork
			inst_read(a);
			data_access(1'b0, b, '0);
		join
		// inst served last so the data side wins the next tie
		inst_read(a);
		wd = random_line();
		fork
			inst_read(b);
			data_access(1'b1, a, wd);
		join
		data_access(1'b0, a, '0);

		repeat (2) @(posedge clk);
		$display("errors: %0d check failures, %0d timeouts", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
